//--- src/mpt_cfg_pkg.sv
// ----------------------------------------------------------------------
// Widths, address and CSR layouts for the 34-bit protection table mode
// Only bare and the 34-bit mode are defined, other modes are reserved
// ----------------------------------------------------------------------
`default_nettype none

package mpt_cfg_pkg;

    // Table entry and memory data width
    localparam int XLEN         = 32;
    // Table page number width
    localparam int PPN_LEN      = 22;
    localparam int MEM_ADDR_LEN = 32;

    // Supervisor physical address, 34 bits
    typedef struct packed {
        logic [8:0]  pn2;     // L2 index, one entry per 32 MiB
        logic [9:0]  pn1;     // L1 index, top three bits pick the 4 MiB sub-page
        logic [2:0]  pn0;     // One of eight 4 KiB pages in an L1 entry
        logic [11:0] offset;
    } spa_t;

    // Protection table CSR
    typedef struct packed {
        logic [1:0]         mode;
        logic [7:0]         sdid;
        logic [PPN_LEN-1:0] ppn;
    } mmpt_reg_t;

    // Codes 2 and 3 are reserved
    typedef enum logic [1:0] {
        MODE_BARE    = 2'd0,
        MODE_SMMPT34 = 2'd1
    } mpt_mode_e;

    typedef enum logic [1:0] {
        ACCESS_NONE  = 2'd0,
        ACCESS_READ  = 2'd1,
        ACCESS_WRITE = 2'd2,
        ACCESS_EXEC  = 2'd3
    } mpt_access_e;

endpackage

`default_nettype wire

//--- src/mpt_entry_pkg.sv
// ----------------------------------------------------------------------
// Table entry layouts, permissions, fault causes and the result entry
// L2 types 6 and 7 are undefined and decode as a format fault
// ----------------------------------------------------------------------
`default_nettype none

package mpt_entry_pkg;

    import mpt_cfg_pkg::*;

    typedef enum logic [1:0] {
        PERM_DISALLOWED = 2'd0,
        PERM_RX         = 2'd1,
        PERM_RW         = 2'd2,
        PERM_RWX        = 2'd3
    } mpt_perm_e;

    typedef enum logic [2:0] {
        L2_RANGE_DISALLOW = 3'd0,
        L2_RANGE_RX       = 3'd1,
        L2_RANGE_RW       = 3'd2,
        L2_RANGE_RWX      = 3'd3,
        L2_L1_DIR         = 3'd4,
        L2_4M_PAGES       = 3'd5
    } mptl2_type_e;

    typedef struct packed {
        logic [6:0]         reserved;
        logic [2:0]         l2_type;
        logic [PPN_LEN-1:0] info;
    } mptl2_entry_t;

    // Page k sits in bits 2k+1 to 2k
    typedef struct packed {
        logic [15:0]     reserved;
        logic [7:0][1:0] page_perm;
    } mptl1_entry_t;

    typedef enum logic [2:0] {
        CAUSE_NONE            = 3'd0,
        CAUSE_RESERVED_BITS   = 3'd1,
        CAUSE_INVALID_L2_INFO = 3'd2,
        CAUSE_UNDEF_L2_TYPE   = 3'd3
    } fault_cause_e;

    // Result of an allowed access, 44 bits
    typedef struct packed {
        logic [7:0] sdid;
        spa_t       spa;
        mpt_perm_e  perm;
    } plb_entry_t;

endpackage

`default_nettype wire

//--- src/mpt_if.sv
// ----------------------------------------------------------------------
// Internal buses of the walker
// walk_req_if fields hold steady from start until the walk ends
// mpt_fetch_if allows a single outstanding table read
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface walk_req_if import mpt_cfg_pkg::*; ();

    logic        start;
    spa_t        spa;
    mpt_access_e access;
    mmpt_reg_t   csr;

    modport src (output start, output spa, output access, output csr);
    modport dst (input start, input spa, input access, input csr);

endinterface

interface mpt_fetch_if import mpt_cfg_pkg::*; ();

    // Issue side, driven by the decoder
    logic                    issue;
    logic [MEM_ADDR_LEN-1:0] addr;

    // Response side, driven by the memory stage
    logic            entry_valid;
    logic [XLEN-1:0] entry;

    modport ctrl (output issue, output addr, input entry_valid, input entry);
    modport fetch (input issue, input addr, output entry_valid, output entry);

endinterface

`default_nettype wire

//--- src/mpt_req_stage.sv
// ----------------------------------------------------------------------
// Request capture stage
// New requests are ignored while busy; busy drops the edge after done
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mpt_req_stage import mpt_cfg_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire logic        ptw_enable_i,
    input  wire logic        addr_valid_i,
    input  wire spa_t        spa_i,
    input  wire mpt_access_e access_type_i,
    input  wire mmpt_reg_t   mmpt_reg_i,
    input  wire logic        done_i,
    output      logic        ptw_busy_o,
    walk_req_if.src          req
);

    logic        accept;
    logic        busy_q;
    logic        start_q;
    spa_t        spa_q;
    mpt_access_e access_q;
    mmpt_reg_t   csr_q;

    assign accept = ptw_enable_i && addr_valid_i && !busy_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            busy_q  <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Snapshot of the request, held for the whole walk
    always_ff @(posedge clk_i) begin
        if (accept) begin
            spa_q    <= spa_i;
            access_q <= access_type_i;
            csr_q    <= mmpt_reg_i;
        end
    end

    assign ptw_busy_o = busy_q;
    assign req.start  = start_q;
    assign req.spa    = spa_q;
    assign req.access = access_q;
    assign req.csr    = csr_q;

endmodule

`default_nettype wire

//--- src/mpt_fetch.sv
// ----------------------------------------------------------------------
// Memory port stage, one table-entry read per issue
// The request is held with a constant address until grant
// Read data is taken on the first valid after the grant cycle
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mpt_fetch import mpt_cfg_pkg::*; (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    input  wire logic                    m_mem_gnt_i,
    input  wire logic                    m_mem_valid_i,
    input  wire logic [XLEN-1:0]         m_mem_rdata_i,
    output      logic                    m_mem_req_o,
    output      logic [MEM_ADDR_LEN-1:0] m_mem_addr_o,
    mpt_fetch_if.fetch                   fetch
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_GNT,
        ST_WAIT_VALID
    } fetch_state_e;

    fetch_state_e            state_q;
    logic [MEM_ADDR_LEN-1:0] addr_q;
    logic [XLEN-1:0]         entry_q;
    logic                    entry_valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q       <= ST_IDLE;
            entry_valid_q <= 1'b0;
        end else begin
            entry_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (fetch.issue) begin
                        state_q <= ST_WAIT_GNT;
                    end
                end
                ST_WAIT_GNT: begin
                    if (m_mem_gnt_i) begin
                        state_q <= ST_WAIT_VALID;
                    end
                end
                ST_WAIT_VALID: begin
                    if (m_mem_valid_i) begin
                        entry_valid_q <= 1'b1;
                        state_q       <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Address and read data carry no reset
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && fetch.issue) begin
            addr_q <= fetch.addr;
        end
        if (state_q == ST_WAIT_VALID && m_mem_valid_i) begin
            entry_q <= m_mem_rdata_i;
        end
    end

    assign m_mem_req_o       = (state_q == ST_WAIT_GNT);
    assign m_mem_addr_o      = addr_q;
    assign fetch.entry_valid = entry_valid_q;
    assign fetch.entry       = entry_q;

endmodule

`default_nettype wire

//--- src/mpt_entry_decode.sv
// ----------------------------------------------------------------------
// Mode check and table-entry decoding, combinational
// Reacts in the same cycle to start or to a returned entry
// A verdict carries either a fault cause or the permission found
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mpt_entry_decode import mpt_cfg_pkg::*; import mpt_entry_pkg::*; (
    input  wire logic   clk_i,
    input  wire logic   rst_ni,
    output logic        verdict_valid_o,
    output fault_cause_e verdict_cause_o,
    output mpt_perm_e   verdict_perm_o,
    walk_req_if.dst     req,
    mpt_fetch_if.ctrl   fetch
);

    typedef enum logic {
        LVL_L2,
        LVL_L1
    } level_e;

    level_e             level_q;
    level_e             level_d;
    logic [PPN_LEN-1:0] next_ppn;
    mptl2_entry_t       l2;
    mptl1_entry_t       l1;

    assign l2 = mptl2_entry_t'(fetch.entry);
    assign l1 = mptl1_entry_t'(fetch.entry);

    always_comb begin
        verdict_valid_o = 1'b0;
        verdict_cause_o = CAUSE_NONE;
        verdict_perm_o  = PERM_DISALLOWED;
        fetch.issue     = 1'b0;
        next_ppn        = '0;
        level_d         = level_q;

        if (req.start) begin
            case (req.csr.mode)
                MODE_BARE: begin
                    // No protection in bare mode
                    verdict_valid_o = 1'b1;
                    verdict_perm_o  = PERM_RWX;
                end
                MODE_SMMPT34: begin
                    next_ppn    = req.csr.ppn + PPN_LEN'(req.spa.pn2);
                    fetch.issue = 1'b1;
                    level_d     = LVL_L2;
                end
                default: begin
                    verdict_valid_o = 1'b1;
                    verdict_cause_o = CAUSE_RESERVED_BITS;
                end
            endcase
        end else if (fetch.entry_valid && level_q == LVL_L2) begin
            verdict_valid_o = 1'b1;
            if (l2.reserved != '0) begin
                verdict_cause_o = CAUSE_RESERVED_BITS;
            end else begin
                case (l2.l2_type)
                    L2_RANGE_DISALLOW, L2_RANGE_RX, L2_RANGE_RW, L2_RANGE_RWX: begin
                        // Whole 32 MiB range, the type code is the permission
                        if (l2.info != '0) begin
                            verdict_cause_o = CAUSE_INVALID_L2_INFO;
                        end else begin
                            verdict_perm_o = mpt_perm_e'(l2.l2_type[1:0]);
                        end
                    end
                    L2_L1_DIR: begin
                        verdict_valid_o = 1'b0;
                        next_ppn        = l2.info + PPN_LEN'(req.spa.pn1);
                        fetch.issue     = 1'b1;
                        level_d         = LVL_L1;
                    end
                    L2_4M_PAGES: begin
                        if (l2.info[21:16] != '0) begin
                            verdict_cause_o = CAUSE_RESERVED_BITS;
                        end else begin
                            verdict_perm_o = mpt_perm_e'(l2.info[{req.spa.pn1[9:7], 1'b0} +: 2]);
                        end
                    end
                    default: verdict_cause_o = CAUSE_UNDEF_L2_TYPE;
                endcase
            end
        end else if (fetch.entry_valid) begin
            verdict_valid_o = 1'b1;
            if (l1.reserved != '0) begin
                verdict_cause_o = CAUSE_RESERVED_BITS;
            end else begin
                verdict_perm_o = mpt_perm_e'(l1.page_perm[req.spa.pn0]);
            end
        end
    end

    assign fetch.addr = MEM_ADDR_LEN'(next_ppn);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            level_q <= LVL_L2;
        end else begin
            level_q <= level_d;
        end
    end

endmodule

`default_nettype wire

//--- src/mpt_resolve.sv
// ----------------------------------------------------------------------
// Access check against the verdict, registered result outputs
// Results are non-zero only in the single ptw_valid_o cycle
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mpt_resolve import mpt_cfg_pkg::*; import mpt_entry_pkg::*; (
    input  wire logic         clk_i,
    input  wire logic         rst_ni,
    input  wire logic         verdict_valid_i,
    input  wire fault_cause_e verdict_cause_i,
    input  wire mpt_perm_e    verdict_perm_i,
    walk_req_if.dst           req,
    output      logic         done_o,
    output      logic         ptw_valid_o,
    output      logic         allow_o,
    output      logic         access_page_fault_o,
    output      fault_cause_e format_error_o,
    output      plb_entry_t   plb_entry_o
);

    logic granted;
    logic allow_d;
    logic fault_d;

    always_comb begin
        case (req.access)
            ACCESS_READ:  granted = (verdict_perm_i != PERM_DISALLOWED);
            ACCESS_WRITE: granted = verdict_perm_i inside {PERM_RW, PERM_RWX};
            ACCESS_EXEC:  granted = verdict_perm_i inside {PERM_RX, PERM_RWX};
            ACCESS_NONE:  granted = 1'b0;
            default:      granted = 1'b0;
        endcase
    end

    // A format error never raises a page fault as well
    assign allow_d = verdict_valid_i && verdict_cause_i == CAUSE_NONE && granted;
    assign fault_d = verdict_valid_i && verdict_cause_i == CAUSE_NONE && !granted;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            ptw_valid_o         <= 1'b0;
            allow_o             <= 1'b0;
            access_page_fault_o <= 1'b0;
            format_error_o      <= CAUSE_NONE;
            plb_entry_o         <= '0;
        end else begin
            ptw_valid_o         <= verdict_valid_i;
            allow_o             <= allow_d;
            access_page_fault_o <= fault_d;
            format_error_o      <= verdict_valid_i ? verdict_cause_i : CAUSE_NONE;
            plb_entry_o         <= allow_d ? {req.csr.sdid, req.spa, verdict_perm_i} : '0;
        end
    end

    assign done_o = ptw_valid_o;

endmodule

`default_nettype wire

//--- src/mpt_walk_top.sv
// ----------------------------------------------------------------------
// Two-level protection table walker, 34-bit mode
// One walk at a time; the memory port only reads
// Grant and valid back-pressure only stretches the walk
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mpt_walk_top import mpt_cfg_pkg::*; import mpt_entry_pkg::*; (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,

    // Request
    input  wire logic                    ptw_enable_i,
    input  wire logic                    addr_valid_i,
    input  wire spa_t                    spa_i,
    input  wire mpt_access_e             access_type_i,
    input  wire mmpt_reg_t               mmpt_reg_i,

    // Status and result
    output      logic                    ptw_busy_o,
    output      logic                    ptw_valid_o,
    output      logic                    allow_o,
    output      logic                    access_page_fault_o,
    output      fault_cause_e            format_error_o,
    output      plb_entry_t              plb_entry_o,

    // Memory port, read only
    output      logic                    m_mem_req_o,
    output      logic [MEM_ADDR_LEN-1:0] m_mem_addr_o,
    input  wire logic                    m_mem_gnt_i,
    input  wire logic                    m_mem_valid_i,
    input  wire logic [XLEN-1:0]         m_mem_rdata_i
);

    logic         done;
    logic         verdict_valid;
    fault_cause_e verdict_cause;
    mpt_perm_e    verdict_perm;

    walk_req_if  u_req_if ();
    mpt_fetch_if u_fetch_if ();

    mpt_req_stage u_req_stage (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .ptw_enable_i  (ptw_enable_i),
        .addr_valid_i  (addr_valid_i),
        .spa_i         (spa_i),
        .access_type_i (access_type_i),
        .mmpt_reg_i    (mmpt_reg_i),
        .done_i        (done),
        .ptw_busy_o    (ptw_busy_o),
        .req           (u_req_if.src)
    );

    mpt_entry_decode u_decode (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .verdict_valid_o (verdict_valid),
        .verdict_cause_o (verdict_cause),
        .verdict_perm_o  (verdict_perm),
        .req             (u_req_if.dst),
        .fetch           (u_fetch_if.ctrl)
    );

    mpt_fetch u_fetch (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .m_mem_gnt_i   (m_mem_gnt_i),
        .m_mem_valid_i (m_mem_valid_i),
        .m_mem_rdata_i (m_mem_rdata_i),
        .m_mem_req_o   (m_mem_req_o),
        .m_mem_addr_o  (m_mem_addr_o),
        .fetch         (u_fetch_if.fetch)
    );

    mpt_resolve u_resolve (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .verdict_valid_i     (verdict_valid),
        .verdict_cause_i     (verdict_cause),
        .verdict_perm_i      (verdict_perm),
        .req                 (u_req_if.dst),
        .done_o              (done),
        .ptw_valid_o         (ptw_valid_o),
        .allow_o             (allow_o),
        .access_page_fault_o (access_page_fault_o),
        .format_error_o      (format_error_o),
        .plb_entry_o         (plb_entry_o)
    );

endmodule

`default_nettype wire

//--- dv/mpt_walk_tb.sv
// ----------------------------------------------------------------------
// Table-driven testbench for the protection table walker
// Inputs and memory responses are driven on falling clock edges
// Grant and valid are delayed 0 to 3 cycles by a fixed-seed xorshift
// Expected fetch addresses use 22-bit page number arithmetic
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mpt_walk_tb import mpt_cfg_pkg::*; import mpt_entry_pkg::*; ();

    // Allowed accesses per permission at bit perm * 4 + access
    localparam logic [15:0] GRANT_MASK = 16'hE6A0;

    typedef struct {
        string        name;
        mmpt_reg_t    csr;
        spa_t         spa;
        mpt_access_e  access;
        logic [31:0]  l2_word;
        logic [31:0]  l1_word;
        logic         allow;
        logic         fault;
        fault_cause_e cause;
        mpt_perm_e    perm;
    } row_t;

    logic         clk_i = 1'b0;
    logic         rst_ni;
    logic         ptw_enable_i;
    logic         addr_valid_i;
    spa_t         spa_i;
    mpt_access_e  access_type_i;
    mmpt_reg_t    mmpt_reg_i;
    logic         ptw_busy_o;
    logic         ptw_valid_o;
    logic         allow_o;
    logic         access_page_fault_o;
    fault_cause_e format_error_o;
    plb_entry_t   plb_entry_o;
    logic         m_mem_req_o;
    logic [31:0]  m_mem_addr_o;
    logic         m_mem_gnt_i;
    logic         m_mem_valid_i;
    logic [31:0]  m_mem_rdata_i;

    row_t        rows[$];
    string       cur_name = "reset";
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [31:0] rng_state = 32'he6592d3c;
    logic [31:0] row_l2;
    logic [31:0] row_l1;
    logic [31:0] fetch_addr [2];
    logic [31:0] req_addr;
    int          fetch_cnt;

    mpt_walk_top u_dut (.*);

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic mmpt_reg_t make_csr(input logic [1:0] mode, input logic [21:0] ppn);
        return {mode, 8'h5a, ppn};
    endfunction

    function automatic spa_t make_spa(input logic [8:0] pn2, input logic [9:0] pn1,
                                      input logic [2:0] pn0);
        return {pn2, pn1, pn0, 12'h234};
    endfunction

    function automatic logic [31:0] l2_word(input logic [6:0] resv, input logic [2:0] typ,
                                            input logic [21:0] info);
        return {resv, typ, info};
    endfunction

    function automatic logic [31:0] l1_word(input logic [15:0] resv, input logic [15:0] perms);
        return {resv, perms};
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Error: %s %s expected %0h actual %0h", cur_name, what, expected, actual);
        end
    endtask

    task automatic add_row(input string name, input mmpt_reg_t csr, input spa_t spa,
                           input mpt_access_e access, input logic [31:0] l2,
                           input logic [31:0] l1, input logic allow, input logic fault,
                           input fault_cause_e cause, input mpt_perm_e perm);
        row_t r;
        r.name    = name;
        r.csr     = csr;
        r.spa     = spa;
        r.access  = access;
        r.l2_word = l2;
        r.l1_word = l1;
        r.allow   = allow;
        r.fault   = fault;
        r.cause   = cause;
        r.perm    = perm;
        rows.push_back(r);
    endtask

    task automatic load_table();
        mmpt_reg_t csr34;
        spa_t      spa_a;
        logic      ok;
        csr34 = make_csr(2'd1, 22'h001000);
        spa_a = make_spa(9'h003, 10'h1a5, 3'd5);
        add_row("bare_read", make_csr(2'd0, 22'h0), spa_a, ACCESS_READ, 0, 0,
                1, 0, CAUSE_NONE, PERM_RWX);
        add_row("bare_none", make_csr(2'd0, 22'h0), spa_a, ACCESS_NONE, 0, 0,
                0, 1, CAUSE_NONE, PERM_RWX);
        add_row("mode2_reserved", make_csr(2'd2, 22'h0), spa_a, ACCESS_READ, 0, 0,
                0, 0, CAUSE_RESERVED_BITS, PERM_DISALLOWED);
        add_row("mode3_reserved", make_csr(2'd3, 22'h0), spa_a, ACCESS_WRITE, 0, 0,
                0, 0, CAUSE_RESERVED_BITS, PERM_DISALLOWED);
        // Every whole-range type against every access type
        for (int t = 0; t < 4; t++) begin
            for (int a = 0; a < 4; a++) begin
                ok = GRANT_MASK[t * 4 + a];
                add_row($sformatf("range_t%0d_a%0d", t, a), csr34, spa_a, mpt_access_e'(2'(a)),
                        l2_word(7'h0, 3'(t), 22'h0), 0, ok, !ok, CAUSE_NONE,
                        mpt_perm_e'(2'(t)));
            end
        end
        add_row("range_info_set", csr34, spa_a, ACCESS_READ, l2_word(7'h0, 3'd1, 22'h000040),
                0, 0, 0, CAUSE_INVALID_L2_INFO, PERM_DISALLOWED);
        add_row("range_resv_set", csr34, spa_a, ACCESS_READ, l2_word(7'h10, 3'd2, 22'h0),
                0, 0, 0, CAUSE_RESERVED_BITS, PERM_DISALLOWED);
        // 4 MiB sub-pages with perm k mod 4 for sub-page k
        add_row("page4m_idx5_exec", csr34, make_spa(9'h003, 10'h283, 3'd0), ACCESS_EXEC,
                l2_word(7'h0, 3'd5, 22'h00e4e4), 0, 1, 0, CAUSE_NONE, PERM_RX);
        add_row("page4m_idx6_exec", csr34, make_spa(9'h003, 10'h300, 3'd0), ACCESS_EXEC,
                l2_word(7'h0, 3'd5, 22'h00e4e4), 0, 0, 1, CAUSE_NONE, PERM_RW);
        add_row("page4m_idx3_write", csr34, make_spa(9'h003, 10'h180, 3'd0), ACCESS_WRITE,
                l2_word(7'h0, 3'd5, 22'h00e4e4), 0, 1, 0, CAUSE_NONE, PERM_RWX);
        add_row("page4m_idx0_read", csr34, make_spa(9'h003, 10'h07f, 3'd0), ACCESS_READ,
                l2_word(7'h0, 3'd5, 22'h00e4e4), 0, 0, 1, CAUSE_NONE, PERM_DISALLOWED);
        add_row("page4m_resv_info", csr34, make_spa(9'h003, 10'h283, 3'd0), ACCESS_READ,
                l2_word(7'h0, 3'd5, 22'h01e4e4), 0, 0, 0, CAUSE_RESERVED_BITS,
                PERM_DISALLOWED);
        // Two-level walks over page_perm pattern 274E
        add_row("l1_pn0_5_read", csr34, make_spa(9'h003, 10'h1a5, 3'd5), ACCESS_READ,
                l2_word(7'h0, 3'd4, 22'h002000), l1_word(16'h0, 16'h274e),
                1, 0, CAUSE_NONE, PERM_RX);
        add_row("l1_pn0_4_write", csr34, make_spa(9'h003, 10'h1a5, 3'd4), ACCESS_WRITE,
                l2_word(7'h0, 3'd4, 22'h002000), l1_word(16'h0, 16'h274e),
                1, 0, CAUSE_NONE, PERM_RWX);
        add_row("l1_pn0_7_read", csr34, make_spa(9'h003, 10'h1a5, 3'd7), ACCESS_READ,
                l2_word(7'h0, 3'd4, 22'h002000), l1_word(16'h0, 16'h274e),
                0, 1, CAUSE_NONE, PERM_DISALLOWED);
        add_row("l1_pn0_0_exec", csr34, make_spa(9'h003, 10'h1a5, 3'd0), ACCESS_EXEC,
                l2_word(7'h0, 3'd4, 22'h002000), l1_word(16'h0, 16'h274e),
                0, 1, CAUSE_NONE, PERM_RW);
        add_row("l1_resv_set", csr34, spa_a, ACCESS_READ, l2_word(7'h0, 3'd4, 22'h002000),
                l1_word(16'h0100, 16'h274e), 0, 0, CAUSE_RESERVED_BITS, PERM_DISALLOWED);
        add_row("l2_dir_resv", csr34, spa_a, ACCESS_READ, l2_word(7'h01, 3'd4, 22'h002000),
                0, 0, 0, CAUSE_RESERVED_BITS, PERM_DISALLOWED);
        add_row("undef_type6", csr34, spa_a, ACCESS_READ, l2_word(7'h0, 3'd6, 22'h0),
                0, 0, 0, CAUSE_UNDEF_L2_TYPE, PERM_DISALLOWED);
        add_row("undef_type7", csr34, spa_a, ACCESS_EXEC, l2_word(7'h0, 3'd7, 22'h000123),
                0, 0, 0, CAUSE_UNDEF_L2_TYPE, PERM_DISALLOWED);
        // Page number sums wrap at 22 bits
        add_row("ppn_wrap_rwx", make_csr(2'd1, 22'h3ffff0), make_spa(9'h1ff, 10'h1a5, 3'd5),
                ACCESS_WRITE, l2_word(7'h0, 3'd3, 22'h0), 0, 1, 0, CAUSE_NONE, PERM_RWX);
        add_row("l1_info_wrap", csr34, spa_a, ACCESS_READ, l2_word(7'h0, 3'd4, 22'h3fff00),
                l1_word(16'h0, 16'h274e), 1, 0, CAUSE_NONE, PERM_RX);
    endtask

    task automatic check_quiet_results(input string what);
        check_value(what, 64'h0, {allow_o, access_page_fault_o, format_error_o, plb_entry_o});
    endtask

    task automatic apply_row(input row_t r);
        int          edges;
        int          exp_fetches;
        logic [21:0] l2_info;
        logic [43:0] exp_plb;
        cur_name      = r.name;
        row_l2        = r.l2_word;
        row_l1        = r.l1_word;
        fetch_cnt     = 0;
        ptw_enable_i  = 1'b1;
        addr_valid_i  = 1'b1;
        spa_i         = r.spa;
        access_type_i = r.access;
        mmpt_reg_i    = r.csr;
        @(negedge clk_i);
        ptw_enable_i = 1'b0;
        addr_valid_i = 1'b0;
        check_value("busy after accept", 1, ptw_busy_o);
        edges = 1;
        while (!ptw_valid_o) begin
            check_quiet_results("results before valid");
            @(negedge clk_i);
            edges++;
        end
        exp_plb = r.allow ? {r.csr.sdid, r.spa, r.perm} : 44'h0;
        check_value("allow", r.allow, allow_o);
        check_value("page fault", r.fault, access_page_fault_o);
        check_value("format cause", r.cause, format_error_o);
        check_value("plb entry", exp_plb, plb_entry_o);
        if (r.csr.mode != 2'd1) begin
            check_value("latency", 2, edges);
        end
        @(negedge clk_i);
        check_value("valid pulse", 0, ptw_valid_o);
        check_value("busy after done", 0, ptw_busy_o);
        check_quiet_results("results after valid");
        // Fetch count and addresses follow the walk rules
        l2_info     = r.l2_word[21:0];
        exp_fetches = (r.csr.mode == 2'd1) ? 1 : 0;
        if (exp_fetches == 1 && r.l2_word[31:25] == 7'h0 && r.l2_word[24:22] == 3'd4) begin
            exp_fetches = 2;
        end
        check_value("fetch count", exp_fetches, fetch_cnt);
        if (exp_fetches >= 1) begin
            check_value("L2 address", {10'h0, r.csr.ppn + 22'(r.spa.pn2)}, fetch_addr[0]);
        end
        if (exp_fetches == 2) begin
            check_value("L1 address", {10'h0, l2_info + 22'(r.spa.pn1)}, fetch_addr[1]);
        end
    endtask

    // Memory responder with random grant and valid delays
    // A request is counted as soon as it shows up on the port
    always begin
        @(negedge clk_i);
        m_mem_gnt_i   = 1'b0;
        m_mem_valid_i = 1'b0;
        if (rst_ni && m_mem_req_o) begin
            req_addr = m_mem_addr_o;
            if (fetch_cnt < 2) begin
                fetch_addr[fetch_cnt] = req_addr;
            end
            fetch_cnt++;
            rng_state = xorshift32(rng_state);
            repeat (rng_state[1:0]) @(negedge clk_i);
            check_value("request held", 1, m_mem_req_o);
            check_value("held address", req_addr, m_mem_addr_o);
            m_mem_gnt_i = 1'b1;
            @(negedge clk_i);
            m_mem_gnt_i = 1'b0;
            rng_state   = xorshift32(rng_state);
            repeat (rng_state[1:0]) @(negedge clk_i);
            m_mem_rdata_i = (fetch_cnt == 1) ? row_l2 : row_l1;
            m_mem_valid_i = 1'b1;
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: no walk result after %0d cycles in %s", cycle_limit, cur_name);
            $display("%0d checks, %0d errors", check_count, error_count + 1);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        rst_ni        = 1'b0;
        ptw_enable_i  = 1'b0;
        addr_valid_i  = 1'b0;
        spa_i         = '0;
        access_type_i = ACCESS_NONE;
        mmpt_reg_i    = '0;
        m_mem_gnt_i   = 1'b0;
        m_mem_valid_i = 1'b0;
        m_mem_rdata_i = '0;
        fetch_cnt     = 0;
        load_table();
        cycle_limit = rows.size() * 40;
        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_value("busy after reset", 0, ptw_busy_o);
        check_value("valid after reset", 0, ptw_valid_o);
        check_value("mem request after reset", 0, m_mem_req_o);
        check_quiet_results("results after reset");
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
src/mpt_cfg_pkg.sv
src/mpt_entry_pkg.sv
src/mpt_if.sv
src/mpt_req_stage.sv
src/mpt_fetch.sv
src/mpt_entry_decode.sv
src/mpt_resolve.sv
src/mpt_walk_top.sv
dv/mpt_walk_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the walker testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f tb.f --top-module mpt_walk_tb -o mpt_walk_sim
./obj_dir/mpt_walk_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "All checks passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
